// ==== design/board_in_sync.sv ====
// Board input conditioning
// Two-flop synchronizer on all switch and button pins, active-low
// buttons turned active high and debounced, switches passed through

module board_in_sync #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           button_0_n,
    input  logic           button_1_n,
    input  logic [9:0]     switch,
    output cr_pkg::t_cr_ro board_in
);
    import cr_pkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    // Synchronizer stages
    logic [1:0]       btn_meta_n;
    logic [1:0]       btn_sync_n;
    logic [9:0]       sw_meta;
    logic [9:0]       sw_sync;
    // Debounce state per button
    logic [1:0]       btn_level;
    logic [1:0]       btn_stable;
    logic [CNT_W-1:0] btn_cnt [2];

    // ------------------------------------------------------------
    // Two-flop synchronizer
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            // Released buttons sit high on the pins
            btn_meta_n <= 2'b11;
            btn_sync_n <= 2'b11;
            sw_meta    <= '0;
            sw_sync    <= '0;
        end else begin
            btn_meta_n <= {button_1_n, button_0_n};
            btn_sync_n <= btn_meta_n;
            sw_meta    <= switch;
            sw_sync    <= sw_meta;
        end
    end

    // Pressed reads as one from here on
    assign btn_level = ~btn_sync_n;

    // ------------------------------------------------------------
    // Debounce
    // ------------------------------------------------------------
    // New level accepted only after DEBOUNCE_CYCLES steady cycles
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (reset) begin
                btn_cnt[i]    <= '0;
                btn_stable[i] <= 1'b0;
            end else if (btn_level[i] == btn_stable[i]) begin
                // Bounce back, restart the count
                btn_cnt[i] <= '0;
            end else if (btn_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                btn_stable[i] <= btn_level[i];
                btn_cnt[i]    <= '0;
            end else begin
                btn_cnt[i] <= btn_cnt[i] + 1'b1;
            end
        end
    end

    assign board_in.button_0 = btn_stable[0];
    assign board_in.button_1 = btn_stable[1];
    assign board_in.switch   = sw_sync;

endmodule

// ==== design/board_out_drive.sv ====
// Seven-segment and LED driver
// Turns each digit code into an active-low segment pattern with the
// decimal point on bit 7, and registers all board output pins

module board_out_drive (
    input  logic        clk,
    input  logic        reset,
    board_out_if.drive  board_out,
    output logic [7:0]  hex_0,
    output logic [7:0]  hex_1,
    output logic [7:0]  hex_2,
    output logic [7:0]  hex_3,
    output logic [7:0]  hex_4,
    output logic [7:0]  hex_5,
    output logic [9:0]  led
);

    // ------------------------------------------------------------
    // Digit code to pins
    // ------------------------------------------------------------
    // Segment order gfedcba, low lights the segment
    function automatic logic [7:0] digit_pins(input logic [7:0] code);
        logic [6:0] seg;
        case (code[3:0])
            4'h0: seg = 7'h40;
            4'h1: seg = 7'h79;
            4'h2: seg = 7'h24;
            4'h3: seg = 7'h30;
            4'h4: seg = 7'h19;
            4'h5: seg = 7'h12;
            4'h6: seg = 7'h02;
            4'h7: seg = 7'h78;
            4'h8: seg = 7'h00;
            4'h9: seg = 7'h10;
            4'hA: seg = 7'h08;
            4'hB: seg = 7'h03;
            4'hC: seg = 7'h46;
            4'hD: seg = 7'h21;
            4'hE: seg = 7'h06;
            default: seg = 7'h0E;
        endcase
        // Blank turns every segment off, point is independent
        if (code[4]) begin
            seg = 7'h7F;
        end
        return {~code[7], seg};
    endfunction

    // ------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            // Dark display, LEDs off
            hex_0 <= 8'hFF;
            hex_1 <= 8'hFF;
            hex_2 <= 8'hFF;
            hex_3 <= 8'hFF;
            hex_4 <= 8'hFF;
            hex_5 <= 8'hFF;
            led   <= 10'd0;
        end else begin
            hex_0 <= digit_pins(board_out.seg7_0);
            hex_1 <= digit_pins(board_out.seg7_1);
            hex_2 <= digit_pins(board_out.seg7_2);
            hex_3 <= digit_pins(board_out.seg7_3);
            hex_4 <= digit_pins(board_out.seg7_4);
            hex_5 <= digit_pins(board_out.seg7_5);
            led   <= board_out.led;
        end
    end

endmodule

// ==== design/board_out_if.sv ====
// Board output registers
// Carries the six digit codes and the LED levels from the register
// file to the segment and LED driver

interface board_out_if;

    // Digit codes, same layout as the core-visible registers
    logic [7:0] seg7_0;
    logic [7:0] seg7_1;
    logic [7:0] seg7_2;
    logic [7:0] seg7_3;
    logic [7:0] seg7_4;
    logic [7:0] seg7_5;
    logic [9:0] led;

    modport mem (
        output seg7_0,
        output seg7_1,
        output seg7_2,
        output seg7_3,
        output seg7_4,
        output seg7_5,
        output led
    );

    modport drive (
        input seg7_0,
        input seg7_1,
        input seg7_2,
        input seg7_3,
        input seg7_4,
        input seg7_5,
        input led
    );

endinterface

// ==== design/cr_access.sv ====
// Core access decoder
// Maps the core load/store address onto a register select and passes
// data and strobes through; misaligned or unmapped offsets select nothing

module cr_access (
    input  logic [31:0] address,
    input  logic [31:0] data,
    input  logic        wren,
    input  logic        rden,
    output logic [31:0] q,
    cr_bus_if.access    bus
);
    import cr_pkg::*;

    t_cr_sel sel;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    always_comb begin
        sel = CR_SEL_NONE;
        // Word access only
        if (address[1:0] == 2'b00) begin
            case (address)
                CR_SEG7_0:   sel = CR_SEL_SEG7_0;
                CR_SEG7_1:   sel = CR_SEL_SEG7_1;
                CR_SEG7_2:   sel = CR_SEL_SEG7_2;
                CR_SEG7_3:   sel = CR_SEL_SEG7_3;
                CR_SEG7_4:   sel = CR_SEL_SEG7_4;
                CR_SEG7_5:   sel = CR_SEL_SEG7_5;
                CR_LED:      sel = CR_SEL_LED;
                CR_BUTTON_0: sel = CR_SEL_BUTTON_0;
                CR_BUTTON_1: sel = CR_SEL_BUTTON_1;
                CR_SWITCH:   sel = CR_SEL_SWITCH;
                // Hole in the map
                default:     sel = CR_SEL_NONE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------
    assign bus.sel   = sel;
    assign bus.wdata = data;
    assign bus.wren  = wren;
    assign bus.rden  = rden;

    // Load data is already registered in the file
    assign q = bus.rdata;

endmodule

// ==== design/cr_bus_if.sv ====
// Decoded core access
// Carries the register select, store data and strobes from the access
// decoder to the register file, and the load data back

interface cr_bus_if;
    import cr_pkg::*;

    // Register select, CR_SEL_NONE for a dropped address
    t_cr_sel     sel;
    logic [31:0] wdata;
    logic        wren;
    logic        rden;
    // Registered load data, one cycle after rden
    logic [31:0] rdata;

    // Decoder side
    modport access (
        output sel,
        output wdata,
        output wren,
        output rden,
        input  rdata
    );

    // Register file side
    modport mem (
        input  sel,
        input  wdata,
        input  wren,
        input  rden,
        output rdata
    );

endinterface

// ==== design/cr_mem.sv ====
// Control-register file
// Flop-based storage for the core-writable digit and LED registers and
// the board-written button and switch registers. Loads return one cycle
// after the request, with a bypass so a same-cycle store is seen.
// The writable registers are mirrored onto the board output interface.

module cr_mem (
    input  logic           clk,
    input  logic           reset,
    cr_bus_if.mem          bus,
    input  cr_pkg::t_cr_ro board_in,
    board_out_if.mem       board_out
);
    import cr_pkg::*;

    t_cr_rw      cr_rw;
    t_cr_rw      cr_rw_next;
    t_cr_ro      cr_ro;
    logic [31:0] pre_rdata;

    // ------------------------------------------------------------
    // Store path
    // ------------------------------------------------------------
    always_comb begin
        cr_rw_next = cr_rw;
        if (bus.wren) begin
            case (bus.sel)
                CR_SEL_SEG7_0: cr_rw_next.seg7_0 = bus.wdata[7:0];
                CR_SEL_SEG7_1: cr_rw_next.seg7_1 = bus.wdata[7:0];
                CR_SEL_SEG7_2: cr_rw_next.seg7_2 = bus.wdata[7:0];
                CR_SEL_SEG7_3: cr_rw_next.seg7_3 = bus.wdata[7:0];
                CR_SEL_SEG7_4: cr_rw_next.seg7_4 = bus.wdata[7:0];
                CR_SEL_SEG7_5: cr_rw_next.seg7_5 = bus.wdata[7:0];
                CR_SEL_LED:    cr_rw_next.led    = bus.wdata[9:0];
                // Read-only and unknown selects keep state
                default:       cr_rw_next = cr_rw;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cr_rw <= CR_RW_RESET;
            cr_ro <= CR_RO_RESET;
        end else begin
            cr_rw <= cr_rw_next;
            // Board side rewrites every cycle
            cr_ro <= board_in;
        end
    end

    // ------------------------------------------------------------
    // Load path
    // ------------------------------------------------------------
    // Writable fields come from next state, giving load-after-store bypass
    always_comb begin
        pre_rdata = 32'd0;
        if (bus.rden) begin
            case (bus.sel)
                CR_SEL_SEG7_0:   pre_rdata = {24'd0, cr_rw_next.seg7_0};
                CR_SEL_SEG7_1:   pre_rdata = {24'd0, cr_rw_next.seg7_1};
                CR_SEL_SEG7_2:   pre_rdata = {24'd0, cr_rw_next.seg7_2};
                CR_SEL_SEG7_3:   pre_rdata = {24'd0, cr_rw_next.seg7_3};
                CR_SEL_SEG7_4:   pre_rdata = {24'd0, cr_rw_next.seg7_4};
                CR_SEL_SEG7_5:   pre_rdata = {24'd0, cr_rw_next.seg7_5};
                CR_SEL_LED:      pre_rdata = {22'd0, cr_rw_next.led};
                // Board registers
                CR_SEL_BUTTON_0: pre_rdata = {31'd0, cr_ro.button_0};
                CR_SEL_BUTTON_1: pre_rdata = {31'd0, cr_ro.button_1};
                CR_SEL_SWITCH:   pre_rdata = {22'd0, cr_ro.switch};
                default:         pre_rdata = 32'd0;
            endcase
        end
    end

    // Registered load data and board mirror
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.rdata        <= 32'd0;
            board_out.seg7_0 <= CR_RW_RESET.seg7_0;
            board_out.seg7_1 <= CR_RW_RESET.seg7_1;
            board_out.seg7_2 <= CR_RW_RESET.seg7_2;
            board_out.seg7_3 <= CR_RW_RESET.seg7_3;
            board_out.seg7_4 <= CR_RW_RESET.seg7_4;
            board_out.seg7_5 <= CR_RW_RESET.seg7_5;
            board_out.led    <= CR_RW_RESET.led;
        end else begin
            bus.rdata        <= pre_rdata;
            board_out.seg7_0 <= cr_rw_next.seg7_0;
            board_out.seg7_1 <= cr_rw_next.seg7_1;
            board_out.seg7_2 <= cr_rw_next.seg7_2;
            board_out.seg7_3 <= cr_rw_next.seg7_3;
            board_out.seg7_4 <= cr_rw_next.seg7_4;
            board_out.seg7_5 <= cr_rw_next.seg7_5;
            board_out.led    <= cr_rw_next.led;
        end
    end

endmodule

// ==== design/cr_pkg.sv ====
// Control-register package
// Register offsets, decoded register select, register layouts and reset
// values shared by the control-register block and its testbench

package cr_pkg;

    // ------------------------------------------------------------
    // Byte offsets of the ten registers
    // ------------------------------------------------------------
    localparam logic [31:0] CR_SEG7_0   = 32'h0000_0000;
    localparam logic [31:0] CR_SEG7_1   = 32'h0000_0004;
    localparam logic [31:0] CR_SEG7_2   = 32'h0000_0008;
    localparam logic [31:0] CR_SEG7_3   = 32'h0000_000C;
    localparam logic [31:0] CR_SEG7_4   = 32'h0000_0010;
    localparam logic [31:0] CR_SEG7_5   = 32'h0000_0014;
    localparam logic [31:0] CR_LED      = 32'h0000_0018;
    // Read-only from the core side
    localparam logic [31:0] CR_BUTTON_0 = 32'h0000_001C;
    localparam logic [31:0] CR_BUTTON_1 = 32'h0000_0020;
    localparam logic [31:0] CR_SWITCH   = 32'h0000_0024;

    // Decoded register select, one value per register
    typedef enum logic [3:0] {
        CR_SEL_SEG7_0,
        CR_SEL_SEG7_1,
        CR_SEL_SEG7_2,
        CR_SEL_SEG7_3,
        CR_SEL_SEG7_4,
        CR_SEL_SEG7_5,
        CR_SEL_LED,
        CR_SEL_BUTTON_0,
        CR_SEL_BUTTON_1,
        CR_SEL_SWITCH,
        CR_SEL_NONE
    } t_cr_sel;

    // ------------------------------------------------------------
    // Register layouts
    // ------------------------------------------------------------
    // Digit code: [3:0] hex value, [4] blank, [7] decimal point, [6:5] spare
    typedef struct packed {
        logic [7:0] seg7_0;
        logic [7:0] seg7_1;
        logic [7:0] seg7_2;
        logic [7:0] seg7_3;
        logic [7:0] seg7_4;
        logic [7:0] seg7_5;
        logic [9:0] led;
    } t_cr_rw;

    // Written by the board every cycle
    typedef struct packed {
        logic       button_0;
        logic       button_1;
        logic [9:0] switch;
    } t_cr_ro;

    // Blank digit, point off
    localparam logic [7:0] CR_SEG7_RESET = 8'h10;

    localparam t_cr_rw CR_RW_RESET = '{
        seg7_0: CR_SEG7_RESET,
        seg7_1: CR_SEG7_RESET,
        seg7_2: CR_SEG7_RESET,
        seg7_3: CR_SEG7_RESET,
        seg7_4: CR_SEG7_RESET,
        seg7_5: CR_SEG7_RESET,
        led:    10'd0
    };

    // Buttons released, switches low
    localparam t_cr_ro CR_RO_RESET = '{button_0: 1'b0, button_1: 1'b0, switch: 10'd0};

endpackage

// ==== design/cr_top.sv ====
// Control-register block top level
// Memory-mapped digit and LED registers written by the core, button and
// switch registers written by the board. Connects the input conditioning,
// access decoder, register file and pin driver.

module cr_top #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic        clk,
    input  logic        reset,
    // Core load/store port
    input  logic [31:0] address,
    input  logic [31:0] data,
    input  logic        wren,
    input  logic        rden,
    output logic [31:0] q,
    // Board inputs, buttons active low
    input  logic        button_0_n,
    input  logic        button_1_n,
    input  logic [9:0]  switch,
    // Board outputs, segments active low
    output logic [7:0]  hex_0,
    output logic [7:0]  hex_1,
    output logic [7:0]  hex_2,
    output logic [7:0]  hex_3,
    output logic [7:0]  hex_4,
    output logic [7:0]  hex_5,
    output logic [9:0]  led
);

    cr_pkg::t_cr_ro board_in;

    cr_bus_if    cr_bus ();
    board_out_if board_out ();

    // ------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------
    board_in_sync #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_board_in_sync (
        .clk        (clk),
        .reset      (reset),
        .button_0_n (button_0_n),
        .button_1_n (button_1_n),
        .switch     (switch),
        .board_in   (board_in)
    );

    cr_access u_cr_access (
        .address (address),
        .data    (data),
        .wren    (wren),
        .rden    (rden),
        .q       (q),
        .bus     (cr_bus.access)
    );

    // ------------------------------------------------------------
    // Register file and output side
    // ------------------------------------------------------------
    cr_mem u_cr_mem (
        .clk       (clk),
        .reset     (reset),
        .bus       (cr_bus.mem),
        .board_in  (board_in),
        .board_out (board_out.mem)
    );

    board_out_drive u_board_out_drive (
        .clk       (clk),
        .reset     (reset),
        .board_out (board_out.drive),
        .hex_0     (hex_0),
        .hex_1     (hex_1),
        .hex_2     (hex_2),
        .hex_3     (hex_3),
        .hex_4     (hex_4),
        .hex_5     (hex_5),
        .led       (led)
    );

endmodule

// ==== sim/cr_tb.sv ====
// Testbench for the control-register block
// Random stores and loads against a reference copy of the registers,
// pin checks two cycles after each store, switch sync and button debounce

module cr_tb;
    import cr_pkg::*;

    // Offsets in register order with digit 0 in the low word
    localparam logic [319:0] REG_ADDR = {CR_SWITCH, CR_BUTTON_1, CR_BUTTON_0, CR_LED,
        CR_SEG7_5, CR_SEG7_4, CR_SEG7_3, CR_SEG7_2, CR_SEG7_1, CR_SEG7_0};
    // Lit segments gfedcba for values F down to 0
    localparam logic [111:0] SEG_ON = {7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F,
        7'h7F, 7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F};

    logic        clk;
    logic        reset;
    logic [31:0] address;
    logic [31:0] data;
    logic        wren;
    logic        rden;
    logic [31:0] q;
    logic        button_0_n;
    logic        button_1_n;
    logic [9:0]  switch;
    logic [7:0]  hex_0;
    logic [7:0]  hex_1;
    logic [7:0]  hex_2;
    logic [7:0]  hex_3;
    logic [7:0]  hex_4;
    logic [7:0]  hex_5;
    logic [9:0]  led;

    // Reference copy with digit i in [8i+7:8i] and led in [57:48]
    logic [57:0] ref_rw;
    logic [9:0]  ref_sw;
    // Copy delayed to pin timing
    logic [57:0] rw_d1;
    logic [57:0] rw_d2;
    logic [31:0] lfsr_state;
    logic [31:0] exp_q;
    logic        exp_valid;
    logic [31:0] chk_q;
    logic        chk_valid;
    logic        pins_on;

    cr_top #(
        .DEBOUNCE_CYCLES (4)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .address    (address),
        .data       (data),
        .wren       (wren),
        .rden       (rden),
        .q          (q),
        .button_0_n (button_0_n),
        .button_1_n (button_1_n),
        .switch     (switch),
        .hex_0      (hex_0),
        .hex_1      (hex_1),
        .hex_2      (hex_2),
        .hex_3      (hex_3),
        .hex_4      (hex_4),
        .hex_5      (hex_5),
        .led        (led)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Random bits and reference model
    // ------------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Blank wins over the value
    // Point is active low on bit 7
    function automatic logic [7:0] seg_ref(input logic [7:0] code);
        logic [6:0] lit;
        lit = code[4] ? 7'h00 : SEG_ON[7*code[3:0] +: 7];
        return {~code[7], ~lit};
    endfunction

    function automatic logic [47:0] hex_ref(input logic [57:0] rw);
        logic [47:0] pins;
        for (int i = 0; i < 6; i++) begin
            pins[8*i +: 8] = seg_ref(rw[8*i +: 8]);
        end
        return pins;
    endfunction

    // Zero for rden low, holes, misaligned offsets and released buttons
    function automatic logic [31:0] expected_q(input logic [31:0] addr, input logic rd);
        logic [31:0] r;
        r = 32'd0;
        for (int i = 0; i < 6; i++) begin
            if (rd && addr == REG_ADDR[32*i +: 32]) r = {24'd0, ref_rw[8*i +: 8]};
        end
        if (rd && addr == CR_LED) r = {22'd0, ref_rw[57:48]};
        if (rd && addr == CR_SWITCH) r = {22'd0, ref_sw};
        return r;
    endfunction

    task automatic store_ref(input logic [31:0] addr, input logic [31:0] wd);
        for (int i = 0; i < 6; i++) begin
            if (addr == REG_ADDR[32*i +: 32]) ref_rw[8*i +: 8] = wd[7:0];
        end
        if (addr == CR_LED) ref_rw[57:48] = wd[9:0];
    endtask

    // ------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR t=%0t %s got 0x%0h expected 0x%0h",
                $time, name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        chk_valid <= exp_valid;
        chk_q     <= exp_q;
        rw_d1     <= ref_rw;
        rw_d2     <= rw_d1;
    end

    // Sampled mid-cycle where q and pins are settled
    always @(negedge clk) begin
        if (chk_valid) begin
            check("q", q, chk_q);
        end
        if (pins_on) begin
            check("hex", {hex_5, hex_4, hex_3, hex_2, hex_1, hex_0}, hex_ref(rw_d2));
            check("led", led, rw_d2[57:48]);
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    // One access per cycle held until the next call
    task automatic do_access(input logic [31:0] addr, input logic [31:0] wd,
                             input logic we, input logic re, input logic chk);
        @(posedge clk);
        #1;
        address = addr;
        data    = wd;
        wren    = we;
        rden    = re;
        if (we) store_ref(addr, wd);
        exp_q     = expected_q(addr, re);
        exp_valid = chk;
    endtask

    // Unchecked load for polling
    task automatic read_reg(input logic [31:0] addr, output logic [31:0] val);
        do_access(addr, 32'd0, 1'b0, 1'b1, 1'b0);
        @(posedge clk);
        #2;
        val = q;
    endtask

    task automatic set_button(input int idx, input logic level_n);
        @(posedge clk);
        #1;
        if (idx == 0) button_0_n = level_n;
        else button_1_n = level_n;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] v;
        int          n;

        reset      = 1'b1;
        address    = '0;
        data       = '0;
        wren       = 1'b0;
        rden       = 1'b0;
        button_0_n = 1'b1;
        button_1_n = 1'b1;
        switch     = '0;
        lfsr_state = 32'h9e17_25c4;
        ref_rw     = {10'd0, {6{CR_SEG7_RESET}}};
        ref_sw     = '0;
        exp_q      = '0;
        exp_valid  = 1'b0;
        pins_on    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset   = 1'b0;
        pins_on = 1'b1;

        // Reset state
        @(negedge clk);
        check("q", q, 0);
        check("led", led, 0);
        check("hex", {hex_5, hex_4, hex_3, hex_2, hex_1, hex_0}, 48'hFFFF_FFFF_FFFF);
        for (int i = 0; i < 6; i++) begin
            do_access(REG_ADDR[32*i +: 32], 32'd0, 1'b0, 1'b1, 1'b1);
        end

        // Writable stores with an optional same-cycle load
        // Then a load of any register
        for (int k = 0; k < 80; k++) begin
            rand_bits(3, r);
            if (r > 6) r = 6;
            rand_bits(32, d);
            rand_bits(1, v);
            do_access(REG_ADDR[32*r +: 32], d, 1'b1, v[0], 1'b1);
            rand_bits(4, r);
            if (r > 9) r = r - 6;
            do_access(REG_ADDR[32*r +: 32], 32'd0, 1'b0, 1'b1, 1'b1);
        end

        // Read-only, misaligned and unused offsets
        for (int k = 0; k < 30; k++) begin
            rand_bits(2, r);
            rand_bits(3, v);
            case (r[1:0])
                2'd0:    a = REG_ADDR[32*(7 + v % 3) +: 32];
                2'd1:    a = REG_ADDR[32*v +: 32] | {30'd0, v[1], 1'b1};
                default: a = 32'h28 + {27'd0, v[2:0], 2'b00};
            endcase
            rand_bits(32, d);
            do_access(a, d, 1'b1, 1'b1, 1'b1);
            do_access(a, d, 1'b0, 1'b1, 1'b1);
        end
        for (int i = 0; i < 10; i++) begin
            do_access(REG_ADDR[32*i +: 32], 32'd0, 1'b0, 1'b1, 1'b1);
        end
        // Load strobe low
        do_access(CR_LED, 32'd0, 1'b0, 1'b0, 1'b1);

        // Switch input through the synchronizer
        // First changed load is the one compared
        for (int k = 0; k < 3; k++) begin
            rand_bits(10, v);
            if (v[9:0] == ref_sw) v[0] = ~v[0];
            @(posedge clk);
            #1;
            switch = v[9:0];
            n = 0;
            d = {22'd0, ref_sw};
            while (d == {22'd0, ref_sw} && n < 10) begin
                read_reg(CR_SWITCH, d);
                n++;
            end
            if (d == {22'd0, ref_sw}) stop_run("switch change never reached the register");
            check("q", d, {22'd0, v[9:0]});
            ref_sw = v[9:0];
        end

        // Button debounce with a short pulse first
        for (int b = 0; b < 2; b++) begin
            a = REG_ADDR[32*(7 + b) +: 32];
            set_button(b, 1'b0);
            set_button(b, 1'b0);
            set_button(b, 1'b1);
            for (int k = 0; k < 12; k++) begin
                read_reg(a, d);
                check("q", d, 0);
            end
            set_button(b, 1'b0);
            n = 0;
            d = 32'd0;
            while (d == 32'd0 && n < 20) begin
                read_reg(a, d);
                n++;
            end
            if (d == 32'd0) stop_run("held button press never read back as pressed");
            check("q", d, 1);
            set_button(b, 1'b1);
            n = 0;
            while (d != 32'd0 && n < 20) begin
                read_reg(a, d);
                n++;
            end
            if (d != 32'd0) stop_run("released button never read back as released");
        end

        do_access(32'd0, 32'd0, 1'b0, 1'b0, 1'b1);
        // Last idle load compared at the negedge in between
        repeat (2) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/cr_pkg.sv
design/cr_bus_if.sv
design/board_out_if.sv
design/board_in_sync.sv
design/cr_access.sv
design/cr_mem.sv
design/board_out_drive.sv
design/cr_top.sv
sim/cr_tb.sv
